// File: source/tv80Pkg.sv
// --------------------
// TV80 bus-cycle engine shared types
// Cycle codes, opcodes and the structs passed between blocks
// --------------------
`default_nettype none

package tv80Pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  oneHot_t;   // Bit 0 is M1 or T1

  // One-hot cycle codes
  localparam oneHot_t CycleFirst = 7'b0000001;
  localparam int IdxM1 = 0;
  localparam int IdxM2 = 1;
  localparam int IdxM3 = 2;
  localparam int IdxT1 = 0;
  localparam int IdxT2 = 1;
  localparam int IdxT3 = 2;
  localparam int IdxT4 = 3;

  // Opcodes known to the decoder
  localparam byte_t OpNop  = 8'h00;
  localparam byte_t OpJp   = 8'hC3;
  localparam byte_t OpDi   = 8'hF3;
  localparam byte_t OpEi   = 8'hFB;
  localparam byte_t OpHalt = 8'h76;

  typedef struct packed {
    logic [2:0] mCycles;   // M-cycles in the instruction
    logic       jump;      // PC from temporary address at the end
    logic       setEi;
    logic       setDi;
    logic       halt;
  } decodeCtrl_t;

  typedef struct packed {
    oneHot_t mCycle;
    oneHot_t tState;
    logic    dataStrobe;   // End of T2 with waitN high
    logic    cycleEnd;
    logic    instrEnd;
  } seqTiming_t;

  typedef struct packed {
    logic nmiCycle;
    logic intCycle;
    logic halted;
  } irqState_t;

endpackage

`default_nettype wire

// File: source/cycleSequencer.sv
// --------------------
// M-cycle and T-state sequencer
// Wait states on T2, bus request parking between cycles
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer
  import tv80Pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        waitN,
  input  logic        busReqN,
  input  decodeCtrl_t ctrl,
  output seqTiming_t  timing,
  output logic        m1N,
  output logic        busAckN
);

  oneHot_t mCycle;
  oneHot_t tState;
  logic    busReqSync;
  logic    busAck;
  logic    lastM;
  logic    lastT;
  logic    stallT2;
  logic    cycleEnd;

  // --------------------
  // Cycle boundaries
  // --------------------
  always_comb
  begin
    lastM    = mCycle[ctrl.mCycles - 3'd1];
    lastT    = mCycle[IdxM1] ? tState[IdxT4] : tState[IdxT3];   // M1 has 4 T-states
    stallT2  = tState[IdxT2] && !waitN;
    // A pending request parks the machine on the last T-state
    cycleEnd = lastT && !busAck && !busReqSync;
  end

  // --------------------
  // State rings
  // --------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      mCycle     <= CycleFirst;
      tState     <= CycleFirst;
      busReqSync <= 1'b0;
      busAck     <= 1'b0;
    end
    else
    begin
      busReqSync <= !busReqN;
      if (cycleEnd)
      begin
        tState <= CycleFirst;
        mCycle <= lastM ? CycleFirst : {mCycle[5:0], mCycle[6]};
      end
      else if (lastT)
      begin
        // Enter, hold or leave acknowledge with the synchronized request
        busAck <= busReqSync;
      end
      else if (!stallT2)
      begin
        tState <= {tState[5:0], tState[6]};
      end
    end
  end

  always_comb
  begin
    timing.mCycle     = mCycle;
    timing.tState     = tState;
    timing.dataStrobe = tState[IdxT2] && waitN;
    timing.cycleEnd   = cycleEnd;
    timing.instrEnd   = cycleEnd && lastM;
  end

  assign m1N     = !(mCycle[IdxM1] && (tState[IdxT1] || tState[IdxT2]));
  assign busAckN = !busAck;

endmodule

`default_nettype wire

// File: source/instrDecode.sv
// --------------------
// Instruction decoder
// Opcode to M-cycle count and control bits
// --------------------
`timescale 1ns/1ps
`default_nettype none

module instrDecode
  import tv80Pkg::*;
(
  input  byte_t       ir,
  output decodeCtrl_t ctrl
);

  always_comb
  begin
    // Anything unknown runs as a one M-cycle NOP
    ctrl.mCycles = 3'd1;
    ctrl.jump    = 1'b0;
    ctrl.setEi   = 1'b0;
    ctrl.setDi   = 1'b0;
    ctrl.halt    = 1'b0;

    case (ir)
      OpJp:
      begin
        ctrl.mCycles = 3'd3;   // Fetch plus two operand reads
        ctrl.jump    = 1'b1;
      end
      OpEi:   ctrl.setEi = 1'b1;
      OpDi:   ctrl.setDi = 1'b1;
      OpHalt: ctrl.halt  = 1'b1;
      OpNop:  ;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/interruptControl.sv
// --------------------
// Interrupt control and halt state
// IFF1, NMI edge latch, acknowledge selection
// --------------------
`timescale 1ns/1ps
`default_nettype none

module interruptControl
  import tv80Pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        intN,
  input  logic        nmiN,
  input  seqTiming_t  timing,
  input  decodeCtrl_t ctrl,
  output irqState_t   irq,
  output logic        haltN,
  output logic        intCycleN,
  output logic        intEnable
);

  logic intReq;
  logic nmiSync;
  logic nmiPrev;
  logic nmiPending;
  logic iff1;
  logic halted;
  logic nmiCycle;
  logic intCycle;
  logic takeNmi;
  logic takeInt;
  logic eiDiSlot;

  always_comb
  begin
    takeNmi  = timing.instrEnd && nmiPending;   // NMI wins
    // No INT straight after EI
    takeInt  = timing.instrEnd && !nmiPending && intReq && iff1 && !ctrl.setEi;
    eiDiSlot = timing.mCycle[IdxM1] && timing.tState[IdxT3];
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      intReq     <= 1'b0;
      nmiSync    <= 1'b1;
      nmiPrev    <= 1'b1;
      nmiPending <= 1'b0;
      iff1       <= 1'b0;
      halted     <= 1'b0;
      nmiCycle   <= 1'b0;
      intCycle   <= 1'b0;
    end
    else
    begin
      intReq  <= !intN;
      nmiSync <= nmiN;
      nmiPrev <= nmiSync;

      if (takeNmi)
        nmiPending <= 1'b0;
      else if (nmiPrev && !nmiSync)
        nmiPending <= 1'b1;   // Falling edge held until taken

      if (eiDiSlot && ctrl.setEi)
        iff1 <= 1'b1;
      else if (eiDiSlot && ctrl.setDi)
        iff1 <= 1'b0;
      else if (takeNmi || takeInt)
        iff1 <= 1'b0;   // Acknowledge masks INT

      if (timing.instrEnd)
      begin
        nmiCycle <= takeNmi;
        intCycle <= takeInt;
      end

      if (takeNmi || takeInt)
        halted <= 1'b0;
      else if (timing.instrEnd && ctrl.halt)
        halted <= 1'b1;
    end
  end

  assign irq       = '{nmiCycle: nmiCycle, intCycle: intCycle, halted: halted};
  assign haltN     = !halted;
  assign intCycleN = !intCycle;
  assign intEnable = iff1;

endmodule

`default_nettype wire

// File: source/addressUnit.sv
// --------------------
// Address unit
// IR, PC, temporary address and address bus
// --------------------
`timescale 1ns/1ps
`default_nettype none

module addressUnit
  import tv80Pkg::*;
#(
  parameter addr_t ResetPc   = 16'h0000,
  parameter addr_t NmiVector = 16'h0066,
  parameter addr_t IntVector = 16'h0038
)
(
  input  logic        clk,
  input  logic        reset_n,
  input  byte_t       dataIn,
  input  seqTiming_t  timing,
  input  decodeCtrl_t ctrl,
  input  irqState_t   irq,
  output byte_t       ir,
  output addr_t       address
);

  addr_t pc;
  addr_t pcNext;
  addr_t tmpAddr;
  logic  ackOrHalt;
  logic  fetchStrobe;
  logic  incPc;

  // --------------------
  // Next PC
  // --------------------
  always_comb
  begin
    ackOrHalt   = irq.nmiCycle || irq.intCycle || irq.halted;
    fetchStrobe = timing.dataStrobe && timing.mCycle[IdxM1];
    // Acknowledge and halt fetches leave PC alone
    incPc       = timing.dataStrobe && !(timing.mCycle[IdxM1] && ackOrHalt);

    pcNext = pc;
    if (timing.instrEnd && irq.nmiCycle)
      pcNext = NmiVector;
    else if (timing.instrEnd && irq.intCycle)
      pcNext = IntVector;
    else if (timing.instrEnd && ctrl.jump)
      pcNext = tmpAddr;
    else if (incPc)
      pcNext = pc + 16'd1;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc      <= ResetPc;
      address <= ResetPc;
      ir      <= OpNop;
    end
    else
    begin
      pc <= pcNext;
      if (timing.cycleEnd)
        address <= pcNext;   // Valid from T1 on
      if (fetchStrobe)
        ir <= ackOrHalt ? OpNop : dataIn;
    end
  end

  // Operand bytes, low byte first
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      tmpAddr <= '0;
    else
    begin
      if (timing.dataStrobe && timing.mCycle[IdxM2])
        tmpAddr[7:0] <= dataIn;
      if (timing.dataStrobe && timing.mCycle[IdxM3])
        tmpAddr[15:8] <= dataIn;
    end
  end

endmodule

`default_nettype wire

// File: source/tv80Top.sv
// --------------------
// TV80 bus-cycle engine top level
// Joins sequencer, decoder, interrupt control and address unit
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tv80Top
  import tv80Pkg::*;
#(
  parameter addr_t ResetPc   = 16'h0000,
  parameter addr_t NmiVector = 16'h0066,
  parameter addr_t IntVector = 16'h0038
)
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    waitN,
  input  logic    intN,
  input  logic    nmiN,
  input  logic    busReqN,
  input  byte_t   dataIn,
  output addr_t   address,
  output logic    m1N,
  output logic    haltN,
  output logic    busAckN,
  output logic    intCycleN,
  output logic    intEnable,
  output oneHot_t mCycle,
  output oneHot_t tState
);

  seqTiming_t  timing;
  decodeCtrl_t ctrl;
  irqState_t   irq;
  byte_t       ir;

  assign mCycle = timing.mCycle;
  assign tState = timing.tState;

  cycleSequencer sequencer_i (
    .clk, .reset_n, .waitN, .busReqN, .ctrl, .timing, .m1N, .busAckN
  );

  instrDecode decode_i (.ir, .ctrl);

  interruptControl interrupt_i (
    .clk, .reset_n, .intN, .nmiN, .timing, .ctrl, .irq,
    .haltN, .intCycleN, .intEnable
  );

  addressUnit #(
    .ResetPc  (ResetPc),
    .NmiVector(NmiVector),
    .IntVector(IntVector)
  ) address_i (
    .clk, .reset_n, .dataIn, .timing, .ctrl, .irq, .ir, .address
  );

endmodule

`default_nettype wire

// File: tests/memoryModel.sv
// --------------------
// Testbench program memory
// 64 KB byte array read at the address bus
// --------------------
`timescale 1ns/1ps
`default_nettype none

module memoryModel
  import tv80Pkg::*;
(
  input  addr_t address,
  output byte_t dataOut
);

  byte_t mem [0:65535];

  assign dataOut = mem[address];   // Asynchronous read

  // Every location back to NOP
  task automatic fillNop();
    for (int a = 0; a < 65536; a++)
      mem[a] = OpNop;
  endtask

  task automatic writeByte(input addr_t addr, input byte_t data);
    mem[addr] = data;
  endtask

endmodule

`default_nettype wire

// File: tests/tv80Tb.sv
// --------------------
// TV80 bus-cycle engine testbench
// Table of scenarios, fetch address and timing checks
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tv80Tb
  import tv80Pkg::*;
();

  localparam int NumRows       = 7;
  localparam int MaxClocks     = 80;
  localparam logic [2:0] SelNone   = 3'd0;
  localparam logic [2:0] SelWait   = 3'd1;
  localparam logic [2:0] SelBusReq = 3'd2;
  localparam logic [2:0] SelInt    = 3'd3;
  localparam logic [2:0] SelNmi    = 3'd4;
  localparam oneHot_t    StateT2   = 7'b0000010;
  localparam oneHot_t    CycleM2   = 7'b0000010;
  localparam oneHot_t    CycleM3   = 7'b0000100;

  typedef struct packed {
    logic [0:7][7:0]  prog;         // Bytes at address 0
    logic [2:0]       pulseSel;     // Which input gets the low pulse
    logic [7:0]       pulseStart;   // Clock index after reset
    logic [7:0]       pulseLen;
    logic [0:7][15:0] expAddr;      // First 8 M1 fetch addresses
    logic [0:7][7:0]  expClk;       // Clock index of each fetch T1
    logic             expHaltN;
    logic             expIntEn;
    logic [3:0]       expIntAck;    // Clocks with intCycleN low
    logic [3:0]       expBusAck;    // Clocks with busAckN low
    logic [3:0]       expHaltLow;   // Clocks with haltN low
    logic [3:0]       expOperand;   // Clocks in M2 or M3
    logic [3:0]       expIeHigh;    // Clocks with intEnable high
  } scenario_t;

  logic    clk;
  logic    reset_n;
  logic    waitN;
  logic    intN;
  logic    nmiN;
  logic    busReqN;
  byte_t   dataIn;
  addr_t   address;
  logic    m1N;
  logic    haltN;
  logic    busAckN;
  logic    intCycleN;
  logic    intEnable;
  oneHot_t mCycle;
  oneHot_t tState;

  scenario_t scenarios [NumRows];
  string     scenarioName [NumRows];

  tv80Top dut_i (
    .clk, .reset_n, .waitN, .intN, .nmiN, .busReqN, .dataIn, .address,
    .m1N, .haltN, .busAckN, .intCycleN, .intEnable, .mCycle, .tState
  );

  memoryModel mem_i (.address, .dataOut(dataIn));

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic setRow(input int idx, input string name, input logic [63:0] prog,
                        input logic [2:0] sel, input logic [7:0] start, input logic [7:0] len,
                        input logic [127:0] addrs, input logic [63:0] clks,
                        input logic expHalt, input logic expIe, input logic [3:0] intAck,
                        input logic [3:0] busAck, input logic [3:0] haltLow,
                        input logic [3:0] operand, input logic [3:0] ieHigh);
    scenarioName[idx]          = name;
    scenarios[idx].prog        = prog;
    scenarios[idx].pulseSel    = sel;
    scenarios[idx].pulseStart  = start;
    scenarios[idx].pulseLen    = len;
    scenarios[idx].expAddr     = addrs;
    scenarios[idx].expClk      = clks;
    scenarios[idx].expHaltN    = expHalt;
    scenarios[idx].expIntEn    = expIe;
    scenarios[idx].expIntAck   = intAck;
    scenarios[idx].expBusAck   = busAck;
    scenarios[idx].expHaltLow  = haltLow;
    scenarios[idx].expOperand  = operand;
    scenarios[idx].expIeHigh   = ieHigh;
  endtask

  // --------------------
  // Scenario table
  // --------------------
  task automatic buildTable();
    setRow(0, "nop stream", 64'h0, SelNone, 0, 0,
           {16'h0000, 16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007},
           {8'd0, 8'd4, 8'd8, 8'd12, 8'd16, 8'd20, 8'd24, 8'd28},
           1'b1, 1'b0, 0, 0, 0, 0, 0);
    setRow(1, "jp nn", 64'hC334120000000000, SelNone, 0, 0,
           {16'h0000, 16'h1234, 16'h1235, 16'h1236, 16'h1237, 16'h1238, 16'h1239, 16'h123A},
           {8'd0, 8'd10, 8'd14, 8'd18, 8'd22, 8'd26, 8'd30, 8'd34},
           1'b1, 1'b0, 0, 0, 0, 6, 0);   // Two 3-clock operand reads
    setRow(2, "wait states", 64'h0, SelWait, 5, 3,   // Second fetch T2
           {16'h0000, 16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007},
           {8'd0, 8'd4, 8'd11, 8'd15, 8'd19, 8'd23, 8'd27, 8'd31},
           1'b1, 1'b0, 0, 0, 0, 0, 0);
    setRow(3, "bus request", 64'h0, SelBusReq, 2, 4,
           {16'h0000, 16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007},
           {8'd0, 8'd9, 8'd13, 8'd17, 8'd21, 8'd25, 8'd29, 8'd33},
           1'b1, 1'b0, 0, 4, 0, 0, 0);
    setRow(4, "halt then nmi", 64'h7600000000000000, SelNmi, 9, 2,
           {16'h0000, 16'h0001, 16'h0001, 16'h0001, 16'h0066, 16'h0067, 16'h0068, 16'h0069},
           {8'd0, 8'd4, 8'd8, 8'd12, 8'd16, 8'd20, 8'd24, 8'd28},
           1'b1, 1'b0, 0, 0, 8, 0, 0);
    setRow(5, "ei then int", 64'hFB00000000000000, SelInt, 0, 8,
           {16'h0000, 16'h0001, 16'h0002, 16'h0038, 16'h0039, 16'h003A, 16'h003B, 16'h003C},
           {8'd0, 8'd4, 8'd8, 8'd12, 8'd16, 8'd20, 8'd24, 8'd28},
           1'b1, 1'b0, 4, 0, 0, 0, 5);   // IFF1 from EI T3 to the NOP end
    // DI after EI masks the same INT
    setRow(6, "ei di then int", 64'hFBF3000000000000, SelInt, 0, 12,
           {16'h0000, 16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005, 16'h0006, 16'h0007},
           {8'd0, 8'd4, 8'd8, 8'd12, 8'd16, 8'd20, 8'd24, 8'd28},
           1'b1, 1'b0, 0, 0, 0, 0, 4);
  endtask

  task automatic runScenario(input int idx);
    scenario_t row;
    string     name;
    int        c;
    int        nFetch;
    int        ackClks;
    int        intAckClks;
    int        haltClks;
    int        operandClks;
    int        ieClks;
    logic      active;
    addr_t     frozenAddr;
    oneHot_t   frozenT;

    row         = scenarios[idx];
    name        = scenarioName[idx];
    nFetch      = 0;
    ackClks     = 0;
    intAckClks  = 0;
    haltClks    = 0;
    operandClks = 0;
    ieClks      = 0;
    frozenAddr  = '0;
    frozenT     = '0;

    reset_n = 1'b0;
    waitN   = 1'b1;
    intN    = 1'b1;
    nmiN    = 1'b1;
    busReqN = 1'b1;
    mem_i.fillNop();
    for (int k = 0; k < 8; k++)
      mem_i.writeByte(addr_t'(k), row.prog[k]);
    repeat (3) @(negedge clk);
    reset_n = 1'b1;   // Clock index 0 starts here

    for (c = 0; c < MaxClocks && nFetch < 8; c++)
    begin
      active = (c >= row.pulseStart) && (c < row.pulseStart + row.pulseLen);

      if (!m1N && tState == CycleFirst)
      begin
        checkValue(name, $sformatf("fetch %0d address", nFetch), row.expAddr[nFetch], address);
        checkValue(name, $sformatf("fetch %0d clock", nFetch), row.expClk[nFetch], c);
        nFetch++;
      end
      if (active && row.pulseSel == SelWait)
        checkValue(name, "tState during wait", StateT2, tState);
      if (!busAckN)
      begin
        if (ackClks == 0)
        begin
          frozenAddr = address;
          frozenT    = tState;
        end
        checkValue(name, "address during bus ack", frozenAddr, address);
        checkValue(name, "tState during bus ack", frozenT, tState);
        ackClks++;
      end
      if (!intCycleN)
        intAckClks++;
      if (!haltN)
        haltClks++;
      if (mCycle == CycleM2 || mCycle == CycleM3)
        operandClks++;
      if (intEnable)
        ieClks++;

      waitN   = !(active && row.pulseSel == SelWait);
      busReqN = !(active && row.pulseSel == SelBusReq);
      intN    = !(active && row.pulseSel == SelInt);
      nmiN    = !(active && row.pulseSel == SelNmi);
      @(negedge clk);
    end

    if (nFetch < 8)
    begin
      $display("Timeout in %s: only %0d of 8 opcode fetches seen in %0d clocks",
               name, nFetch, MaxClocks);
      $display("TEST FAILED");
      $fatal(1);
    end
    checkValue(name, "final haltN", row.expHaltN, haltN);
    checkValue(name, "final intEnable", row.expIntEn, intEnable);
    checkValue(name, "intCycleN low clocks", row.expIntAck, intAckClks);
    checkValue(name, "busAckN low clocks", row.expBusAck, ackClks);
    checkValue(name, "haltN low clocks", row.expHaltLow, haltClks);
    checkValue(name, "M2 and M3 clocks", row.expOperand, operandClks);
    checkValue(name, "intEnable high clocks", row.expIeHigh, ieClks);
  endtask

  initial
  begin
    reset_n = 1'b0;
    waitN   = 1'b1;
    intN    = 1'b1;
    nmiN    = 1'b1;
    busReqN = 1'b1;
    buildTable();
    for (int i = 0; i < NumRows; i++)
      runScenario(i);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
source/tv80Pkg.sv
source/cycleSequencer.sv
source/instrDecode.sv
source/interruptControl.sv
source/addressUnit.sv
source/tv80Top.sv
tests/memoryModel.sv
tests/tv80Tb.sv
